//--- src/mipi_rx_pkg.sv
`default_nettype none

package mipi_rx_pkg;

    // --------------------
    // Widths and defaults
    // --------------------
    localparam int WORD_W     = 48;
    localparam int LANE_BYTES = 6;
    localparam int LEN_W      = 24;

    localparam logic [WORD_W-1:0] SOF_DEFAULT = 48'hEA_FF_99_DE_AD_FF;
    localparam logic [WORD_W-1:0] EOF_DEFAULT = 48'hEA_FF_99_DE_AD_AA;
    localparam logic [7:0]        I2C_APP_ID_DEFAULT = 8'd7;

    typedef logic [WORD_W-1:0] word_t;

    // --------------------
    // Bundles
    // --------------------
    typedef struct packed {
        logic [7:0]       app_id;  // Header bits 47:40.
        logic [LEN_W-1:0] length;  // Payload words.
        logic [7:0]       mask;    // Last word byte mask.
    } frame_hdr_t;

    typedef struct packed {
        word_t data;
        logic  write;
        logic  commit;
        logic  discard;
    } buf_wr_t;

    typedef struct packed {
        logic [7:0] data;
        logic       write;
    } byte_wr_t;

    // --------------------
    // States and selectors
    // --------------------
    typedef enum logic [1:0] {
        HUNT_SOF,
        GET_HEADER,
        GET_DATA,
        CHECK_EOF
    } frame_state_t;

    typedef enum logic [1:0] {
        UNP_IDLE,
        UNP_HEADER,
        UNP_LOAD,
        UNP_BYTES
    } unpack_state_t;

    typedef enum logic {
        DEST_UART,
        DEST_I2C
    } dest_t;

endpackage

`default_nettype wire

//--- src/frame_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module frame_fsm #(
    parameter mipi_rx_pkg::word_t SOF_WORD = mipi_rx_pkg::SOF_DEFAULT,
    parameter mipi_rx_pkg::word_t EOF_WORD = mipi_rx_pkg::EOF_DEFAULT
) (
    input  wire logic                          rx_pixel_clk,
    input  wire logic                          arst_n,
    input  wire mipi_rx_pkg::word_t            rx_word,
    input  wire logic                          rx_valid,
    input  wire logic                          buf_full,
    input  wire logic                          cnt_last,
    input  wire logic                          cnt_zero,
    output mipi_rx_pkg::buf_wr_t               buf_wr,
    output logic                               cnt_load,
    output logic                               cnt_dec,
    output logic [mipi_rx_pkg::LEN_W-1:0]      cnt_init
);

    import mipi_rx_pkg::*;

    frame_state_t state;
    frame_state_t state_nxt;
    frame_hdr_t   hdr;
    logic         eof_ok;

    assign hdr      = frame_hdr_t'(rx_word[WORD_W-1:8]);
    assign cnt_init = hdr.length;
    assign eof_ok   = (rx_word == EOF_WORD) && cnt_zero;  // Counter must be drained too.

    always_comb begin
        state_nxt   = state;
        buf_wr      = '0;
        buf_wr.data = rx_word;
        cnt_load    = 1'b0;
        cnt_dec     = 1'b0;
        if (rx_valid) begin
            case (state)
                HUNT_SOF: begin
                    if (rx_word == SOF_WORD) begin
                        state_nxt = GET_HEADER;
                    end
                end
                GET_HEADER: begin
                    if (buf_full) begin
                        buf_wr.discard = 1'b1;  // No room, drop frame.
                        state_nxt      = HUNT_SOF;
                    end else begin
                        buf_wr.write = 1'b1;
                        cnt_load     = 1'b1;
                        state_nxt    = (hdr.length == '0) ? CHECK_EOF : GET_DATA;
                    end
                end
                GET_DATA: begin
                    if (buf_full) begin
                        buf_wr.discard = 1'b1;
                        state_nxt      = HUNT_SOF;
                    end else begin
                        buf_wr.write = 1'b1;
                        cnt_dec      = 1'b1;
                        state_nxt    = cnt_last ? CHECK_EOF : GET_DATA;
                    end
                end
                CHECK_EOF: begin
                    buf_wr.commit  = eof_ok;
                    buf_wr.discard = !eof_ok;
                    state_nxt      = HUNT_SOF;  // Mismatch word is not re-hunted.
                end
                default: begin
                    state_nxt = HUNT_SOF;
                end
            endcase
        end
    end

    always_ff @(posedge rx_pixel_clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= HUNT_SOF;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

`default_nettype wire

//--- src/word_counter.sv
`timescale 1ns/10ps
`default_nettype none

module word_counter (
    input  wire logic                          rx_pixel_clk,
    input  wire logic                          arst_n,
    input  wire logic                          load,
    input  wire logic                          dec,
    input  wire logic [mipi_rx_pkg::LEN_W-1:0] init,
    output logic                               last,
    output logic                               zero
);

    import mipi_rx_pkg::*;

    logic [LEN_W-1:0] count;
    logic [LEN_W-1:0] count_nxt;

    always_comb begin
        count_nxt = count;
        if (load) begin
            count_nxt = init;
        end else if (dec && (count != '0)) begin
            count_nxt = count - 1'b1;
        end
    end

    // Flags track the new count so they line up with it.
    always_ff @(posedge rx_pixel_clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
            last  <= 1'b0;
            zero  <= 1'b1;
        end else begin
            count <= count_nxt;
            last  <= (count_nxt == LEN_W'(1));
            zero  <= (count_nxt == '0);
        end
    end

endmodule

`default_nettype wire

//--- src/frame_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module frame_buffer #(
    parameter int BUF_ADDR_W = 6
) (
    input  wire logic                 rx_pixel_clk,
    input  wire logic                 arst_n,
    input  wire mipi_rx_pkg::buf_wr_t buf_wr,
    input  wire logic                 buf_re,
    output mipi_rx_pkg::word_t        buf_rd_data,
    output logic                      buf_empty,
    output logic                      buf_full
);

    import mipi_rx_pkg::*;

    localparam int DEPTH = 2 ** BUF_ADDR_W;

    word_t mem [DEPTH];

    // Extra top bit separates full from empty.
    logic [BUF_ADDR_W:0] rd_ptr;
    logic [BUF_ADDR_W:0] cm_ptr;  // Committed write pointer.
    logic [BUF_ADDR_W:0] wr_ptr;  // Tentative write pointer.
    logic [BUF_ADDR_W:0] wr_ptr_inc;

    assign wr_ptr_inc  = wr_ptr + 1'b1;
    assign buf_empty   = (rd_ptr == cm_ptr);
    assign buf_full    = (wr_ptr[BUF_ADDR_W] != rd_ptr[BUF_ADDR_W]) &&
                         (wr_ptr[BUF_ADDR_W-1:0] == rd_ptr[BUF_ADDR_W-1:0]);
    assign buf_rd_data = mem[rd_ptr[BUF_ADDR_W-1:0]];  // Show-ahead.

    always_ff @(posedge rx_pixel_clk) begin
        if (buf_wr.write) begin
            mem[wr_ptr[BUF_ADDR_W-1:0]] <= buf_wr.data;
        end
    end

    // --------------------
    // Pointer control
    // --------------------
    always_ff @(posedge rx_pixel_clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            cm_ptr <= '0;
            wr_ptr <= '0;
        end else begin
            if (buf_wr.discard) begin
                wr_ptr <= cm_ptr;  // Whole frame vanishes.
            end else if (buf_wr.write) begin
                wr_ptr <= wr_ptr_inc;
            end
            if (buf_wr.commit) begin
                cm_ptr <= buf_wr.write ? wr_ptr_inc : wr_ptr;
            end
            if (buf_re && !buf_empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/byte_unpacker.sv
`timescale 1ns/10ps
`default_nettype none

module byte_unpacker #(
    parameter logic [7:0] I2C_APP_ID = mipi_rx_pkg::I2C_APP_ID_DEFAULT
) (
    input  wire logic                  rx_pixel_clk,
    input  wire logic                  arst_n,
    input  wire mipi_rx_pkg::word_t    buf_rd_data,
    input  wire logic                  buf_empty,
    input  wire logic                  uart_full,
    input  wire logic                  i2c_full,
    output logic                       buf_re,
    output mipi_rx_pkg::byte_wr_t      uart_wr,
    output mipi_rx_pkg::byte_wr_t      i2c_wr
);

    import mipi_rx_pkg::*;

    unpack_state_t    state;
    frame_hdr_t       hdr;
    frame_hdr_t       hdr_in;
    dest_t            dest;
    word_t            shift;
    logic [LEN_W-1:0] words_left;
    logic [2:0]       bytes_left;
    logic             target_full;
    logic             emit;

    function automatic logic [2:0] last_bytes(input logic [7:0] mask);
        case (mask)
            8'd1:    return 3'd1;
            8'd3:    return 3'd2;
            8'd7:    return 3'd3;
            8'd15:   return 3'd4;
            8'd31:   return 3'd5;
            default: return 3'(LANE_BYTES);
        endcase
    endfunction

    assign hdr_in      = frame_hdr_t'(buf_rd_data[WORD_W-1:8]);
    assign dest        = (hdr.app_id == I2C_APP_ID) ? DEST_I2C : DEST_UART;
    assign target_full = (dest == DEST_I2C) ? i2c_full : uart_full;
    assign emit        = (state == UNP_BYTES) && !target_full;
    assign buf_re      = !buf_empty && ((state == UNP_HEADER) || (state == UNP_LOAD));

    // Lane 0 sits in the top byte.
    assign uart_wr.data  = shift[WORD_W-1 -: 8];
    assign uart_wr.write = emit && (dest == DEST_UART);
    assign i2c_wr.data   = shift[WORD_W-1 -: 8];
    assign i2c_wr.write  = emit && (dest == DEST_I2C);

    always_ff @(posedge rx_pixel_clk) begin
        if ((state == UNP_HEADER) && buf_re) begin
            hdr <= hdr_in;
        end
        if ((state == UNP_LOAD) && buf_re) begin
            shift <= buf_rd_data;
        end else if (emit) begin
            shift <= shift << 8;
        end
    end

    // --------------------
    // Unpack FSM
    // --------------------
    always_ff @(posedge rx_pixel_clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= UNP_IDLE;
            words_left <= '0;
            bytes_left <= '0;
        end else begin
            case (state)
                UNP_IDLE: begin
                    if (!buf_empty) begin
                        state <= UNP_HEADER;
                    end
                end
                UNP_HEADER: begin
                    if (buf_re) begin
                        words_left <= hdr_in.length;
                        state      <= (hdr_in.length == '0) ? UNP_IDLE : UNP_LOAD;
                    end
                end
                UNP_LOAD: begin
                    if (buf_re) begin
                        words_left <= words_left - 1'b1;
                        bytes_left <= (words_left == LEN_W'(1)) ? last_bytes(hdr.mask)
                                                                : 3'(LANE_BYTES);
                        state      <= UNP_BYTES;
                    end
                end
                UNP_BYTES: begin
                    if (emit) begin
                        bytes_left <= bytes_left - 1'b1;
                        if (bytes_left == 3'd1) begin
                            state <= (words_left == '0) ? UNP_IDLE : UNP_LOAD;
                        end
                    end
                end
                default: begin
                    state <= UNP_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/byte_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module byte_fifo #(
    parameter int ADDR_W = 5
) (
    input  wire logic                  rx_pixel_clk,
    input  wire logic                  arst_n,
    input  wire mipi_rx_pkg::byte_wr_t wr,
    input  wire logic                  re,
    output logic [7:0]                 rd_data,
    output logic                       empty,
    output logic                       full
);

    localparam int DEPTH = 2 ** ADDR_W;

    logic [7:0]      mem [DEPTH];
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic [ADDR_W:0]   count;
    logic              do_wr;
    logic              do_rd;

    assign empty   = (count == '0);
    assign full    = (count == (ADDR_W + 1)'(DEPTH));
    assign do_wr   = wr.write && !full;
    assign do_rd   = re && !empty;  // Empty reads are dropped.
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge rx_pixel_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr.data;
        end
    end

    always_ff @(posedge rx_pixel_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (ADDR_W + 1)'(do_wr) - (ADDR_W + 1)'(do_rd);
        end
    end

endmodule

`default_nettype wire

//--- src/mipi_rx_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module mipi_rx_decoder #(
    parameter mipi_rx_pkg::word_t SOF_WORD   = mipi_rx_pkg::SOF_DEFAULT,
    parameter mipi_rx_pkg::word_t EOF_WORD   = mipi_rx_pkg::EOF_DEFAULT,
    parameter logic [7:0]         I2C_APP_ID = mipi_rx_pkg::I2C_APP_ID_DEFAULT,
    parameter int                 BUF_ADDR_W = 6,
    parameter int                 OUT_ADDR_W = 5
) (
    input  wire logic        rx_pixel_clk,
    input  wire logic        arst_n,
    input  wire logic [63:0] mipi_rx_data,
    input  wire logic        mipi_rx_valid,
    input  wire logic        uart_fifo_re,
    input  wire logic        i2c_fifo_re,
    output logic [7:0]       uart_data,
    output logic [7:0]       i2c_data,
    output logic             uart_fifo_empty,
    output logic             i2c_fifo_empty
);

    import mipi_rx_pkg::*;

    word_t            rx_word;
    buf_wr_t          buf_wr;
    logic             buf_full;
    logic             buf_empty;
    logic             buf_re;
    word_t            buf_rd_data;
    logic             cnt_load;
    logic             cnt_dec;
    logic [LEN_W-1:0] cnt_init;
    logic             cnt_last;
    logic             cnt_zero;
    byte_wr_t         uart_wr;
    byte_wr_t         i2c_wr;
    logic             uart_full;
    logic             i2c_full;

    // Lane 0 goes to the top byte; lanes 6 and 7 are dropped.
    always_comb begin
        for (int i = 0; i < LANE_BYTES; i++) begin
            rx_word[WORD_W-1-8*i -: 8] = mipi_rx_data[8*i +: 8];
        end
    end

    frame_fsm #(
        .SOF_WORD (SOF_WORD),
        .EOF_WORD (EOF_WORD)
    ) u_frame_fsm (
        .rx_pixel_clk (rx_pixel_clk),
        .arst_n       (arst_n),
        .rx_word      (rx_word),
        .rx_valid     (mipi_rx_valid),
        .buf_full     (buf_full),
        .cnt_last     (cnt_last),
        .cnt_zero     (cnt_zero),
        .buf_wr       (buf_wr),
        .cnt_load     (cnt_load),
        .cnt_dec      (cnt_dec),
        .cnt_init     (cnt_init)
    );

    word_counter u_word_counter (
        .rx_pixel_clk (rx_pixel_clk),
        .arst_n       (arst_n),
        .load         (cnt_load),
        .dec          (cnt_dec),
        .init         (cnt_init),
        .last         (cnt_last),
        .zero         (cnt_zero)
    );

    frame_buffer #(
        .BUF_ADDR_W (BUF_ADDR_W)
    ) u_frame_buffer (
        .rx_pixel_clk (rx_pixel_clk),
        .arst_n       (arst_n),
        .buf_wr       (buf_wr),
        .buf_re       (buf_re),
        .buf_rd_data  (buf_rd_data),
        .buf_empty    (buf_empty),
        .buf_full     (buf_full)
    );

    byte_unpacker #(
        .I2C_APP_ID (I2C_APP_ID)
    ) u_byte_unpacker (
        .rx_pixel_clk (rx_pixel_clk),
        .arst_n       (arst_n),
        .buf_rd_data  (buf_rd_data),
        .buf_empty    (buf_empty),
        .uart_full    (uart_full),
        .i2c_full     (i2c_full),
        .buf_re       (buf_re),
        .uart_wr      (uart_wr),
        .i2c_wr       (i2c_wr)
    );

    // --------------------
    // Output FIFOs
    // --------------------
    byte_fifo #(
        .ADDR_W (OUT_ADDR_W)
    ) uart_fifo (
        .rx_pixel_clk (rx_pixel_clk),
        .arst_n       (arst_n),
        .wr           (uart_wr),
        .re           (uart_fifo_re),
        .rd_data      (uart_data),
        .empty        (uart_fifo_empty),
        .full         (uart_full)
    );

    byte_fifo #(
        .ADDR_W (OUT_ADDR_W)
    ) i2c_fifo (
        .rx_pixel_clk (rx_pixel_clk),
        .arst_n       (arst_n),
        .wr           (i2c_wr),
        .re           (i2c_fifo_re),
        .rd_data      (i2c_data),
        .empty        (i2c_fifo_empty),
        .full         (i2c_full)
    );

endmodule

`default_nettype wire

//--- tests/mipi_rx_decoder_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module rx_decoder_asserts (
    input wire logic                  rx_pixel_clk,
    input wire logic                  arst_n,
    input wire mipi_rx_pkg::buf_wr_t  buf_wr,
    input wire mipi_rx_pkg::byte_wr_t uart_wr,
    input wire mipi_rx_pkg::byte_wr_t i2c_wr,
    input wire logic                  uart_full,
    input wire logic                  i2c_full
);

    // --------------------
    // Frame buffer side
    // --------------------
    commit_or_discard: assert property (@(posedge rx_pixel_clk) disable iff (!arst_n)
        !(buf_wr.commit && buf_wr.discard))
        else $error("frame buffer got commit and discard in one cycle");

    // --------------------
    // Unpacker side
    // --------------------
    uart_room: assert property (@(posedge rx_pixel_clk) disable iff (!arst_n)
        uart_wr.write |-> !uart_full)
        else $error("byte written to a full UART FIFO");

    i2c_room: assert property (@(posedge rx_pixel_clk) disable iff (!arst_n)
        i2c_wr.write |-> !i2c_full)
        else $error("byte written to a full I2C FIFO");

    one_target: assert property (@(posedge rx_pixel_clk) disable iff (!arst_n)
        !(uart_wr.write && i2c_wr.write))
        else $error("UART and I2C written in one cycle");

endmodule

// Both interfaces meet in the top level.
bind mipi_rx_decoder rx_decoder_asserts u_rx_decoder_asserts (
    .rx_pixel_clk (rx_pixel_clk),
    .arst_n       (arst_n),
    .buf_wr       (buf_wr),
    .uart_wr      (uart_wr),
    .i2c_wr       (i2c_wr),
    .uart_full    (uart_full),
    .i2c_full     (i2c_full)
);

`default_nettype wire

//--- tests/tb_mipi_rx_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mipi_rx_decoder;

    import mipi_rx_pkg::*;

    localparam int         ROWS       = 11;
    localparam int         JUNK_WORDS = 2;
    localparam logic [7:0] I2C_ID     = I2C_APP_ID_DEFAULT;

    typedef struct packed {
        frame_hdr_t hdr;
        logic       bad_eof;  // Corrupt end-of-frame word.
        logic [3:0] gap;      // Idle cycles before the frame.
        logic       live;     // Outputs read while the frame goes in.
    } frame_row_t;

    logic        rx_pixel_clk = 1'b0;
    logic        arst_n;
    logic [63:0] mipi_rx_data;
    logic        mipi_rx_valid;
    logic        uart_fifo_re = 1'b0;
    logic        i2c_fifo_re  = 1'b0;
    logic [7:0]  uart_data;
    logic [7:0]  i2c_data;
    logic        uart_fifo_empty;
    logic        i2c_fifo_empty;

    frame_row_t  rows [ROWS];
    logic [7:0]  uart_q [$];
    logic [7:0]  i2c_q [$];
    logic [15:0] lfsr;
    logic        read_on;
    int          cycles;
    int          cycle_limit;
    int          errors;

    mipi_rx_decoder #(
        .SOF_WORD   (SOF_DEFAULT),
        .EOF_WORD   (EOF_DEFAULT),
        .I2C_APP_ID (I2C_ID),
        .BUF_ADDR_W (6),
        .OUT_ADDR_W (5)
    ) dut (
        .rx_pixel_clk    (rx_pixel_clk),
        .arst_n          (arst_n),
        .mipi_rx_data    (mipi_rx_data),
        .mipi_rx_valid   (mipi_rx_valid),
        .uart_fifo_re    (uart_fifo_re),
        .i2c_fifo_re     (i2c_fifo_re),
        .uart_data       (uart_data),
        .i2c_data        (i2c_data),
        .uart_fifo_empty (uart_fifo_empty),
        .i2c_fifo_empty  (i2c_fifo_empty)
    );

    always #5 rx_pixel_clk = ~rx_pixel_clk;

    // --------------------
    // Random source
    // --------------------
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;  // Taps 16, 14, 13, 11.
        end
        return n;
    endfunction

    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[62:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return r;
    endfunction

    // --------------------
    // Frame building
    // --------------------
    function automatic logic [63:0] to_lanes(input word_t w);
        logic [63:0] d;
        logic [63:0] hi;
        hi = take_bits(16);
        d  = {hi[15:0], 48'h0};  // Lanes 6 and 7 carry noise.
        for (int i = 0; i < LANE_BYTES; i++) begin
            d[8*i +: 8] = w[WORD_W-1-8*i -: 8];
        end
        return d;
    endfunction

    function automatic int mask_bytes(input logic [7:0] mask);
        case (mask)
            8'd1:    return 1;
            8'd3:    return 2;
            8'd7:    return 3;
            8'd15:   return 4;
            8'd31:   return 5;
            default: return 6;
        endcase
    endfunction

    function automatic frame_row_t make_row(input logic [7:0] id, input int len,
                                            input logic [7:0] mask, input logic bad,
                                            input int gap, input logic live);
        frame_row_t r;
        r.hdr.app_id = id;
        r.hdr.length = LEN_W'(len);
        r.hdr.mask   = mask;
        r.bad_eof    = bad;
        r.gap        = 4'(gap);
        r.live       = live;
        return r;
    endfunction

    task automatic send_word(input logic [63:0] data);
        logic [63:0] bits;
        bits = take_bits(2);
        while (bits[1:0] == 2'b00) begin
            @(posedge rx_pixel_clk);
            mipi_rx_valid <= 1'b0;
            mipi_rx_data  <= take_bits(64);
            bits = take_bits(2);
        end
        @(posedge rx_pixel_clk);
        mipi_rx_valid <= 1'b1;
        mipi_rx_data  <= data;
    endtask

    task automatic run_row(input frame_row_t r);
        logic [63:0] bits;
        logic [63:0] data;
        word_t       junk;
        dest_t       dest;
        int          len;
        int          count;
        len  = int'(r.hdr.length);
        dest = (r.hdr.app_id == I2C_ID) ? DEST_I2C : DEST_UART;
        read_on <= r.live;
        for (int g = 0; g < int'(r.gap); g++) begin
            @(posedge rx_pixel_clk);
            mipi_rx_valid <= 1'b0;
            mipi_rx_data  <= take_bits(64);
        end
        for (int j = 0; j < JUNK_WORDS; j++) begin
            bits = take_bits(48);
            junk = bits[47:0];
            if (junk == SOF_DEFAULT) begin
                junk[0] = ~junk[0];
            end
            send_word(to_lanes(junk));
        end
        send_word(to_lanes(SOF_DEFAULT));
        bits = take_bits(8);
        send_word(to_lanes({r.hdr, bits[7:0]}));  // Low byte is unused.
        for (int w = 0; w < len; w++) begin
            count = (w == len - 1) ? mask_bytes(r.hdr.mask) : LANE_BYTES;
            data  = '0;
            for (int k = 0; k < LANE_BYTES; k++) begin
                bits = take_bits(8);
                data[8*k +: 8] = bits[7:0];
                if (!r.bad_eof && (k < count)) begin
                    if (dest == DEST_I2C) begin
                        i2c_q.push_back(bits[7:0]);
                    end else begin
                        uart_q.push_back(bits[7:0]);
                    end
                end
            end
            bits = take_bits(16);
            data[63:48] = bits[15:0];
            send_word(data);
        end
        send_word(to_lanes(r.bad_eof ? (EOF_DEFAULT ^ 48'h1) : EOF_DEFAULT));
    endtask

    // --------------------
    // Checks
    // --------------------
    task automatic stop_run();
        errors++;
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_uart_byte(input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("FAIL uart_data got %h expected %h", got, exp);
            stop_run();
        end
    endtask

    task automatic check_i2c_byte(input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("FAIL i2c_data got %h expected %h", got, exp);
            stop_run();
        end
    endtask

    task automatic check_empty(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    // A byte leaves a FIFO on every edge where its strobe is high and it is not empty.
    always @(posedge rx_pixel_clk) begin
        if (uart_fifo_re && !uart_fifo_empty) begin
            if (uart_q.size() == 0) begin
                $display("UART output gave a byte that no good frame carries");
                stop_run();
            end else begin
                check_uart_byte(uart_data, uart_q.pop_front());
            end
        end
        if (i2c_fifo_re && !i2c_fifo_empty) begin
            if (i2c_q.size() == 0) begin
                $display("I2C output gave a byte that no good frame carries");
                stop_run();
            end else begin
                check_i2c_byte(i2c_data, i2c_q.pop_front());
            end
        end
        uart_fifo_re <= read_on;
        i2c_fifo_re  <= read_on;
    end

    always @(posedge rx_pixel_clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles with bytes still missing", cycle_limit);
            stop_run();
        end
    end

    initial begin
        arst_n        = 1'b0;
        mipi_rx_data  = '0;
        mipi_rx_valid = 1'b0;
        read_on       = 1'b0;
        lfsr          = 16'd6871;
        errors        = 0;

        //                  id     len mask   bad   gap live
        rows[0]  = make_row(8'h21, 3, 8'd7,  1'b0, 2, 1'b1);
        rows[1]  = make_row(8'h07, 2, 8'd1,  1'b0, 1, 1'b1);
        rows[2]  = make_row(8'h07, 1, 8'd31, 1'b0, 0, 1'b1);
        rows[3]  = make_row(8'h07, 2, 8'd0,  1'b0, 3, 1'b1);
        rows[4]  = make_row(8'h33, 2, 8'd15, 1'b1, 1, 1'b1);
        rows[5]  = make_row(8'h33, 2, 8'd15, 1'b0, 0, 1'b1);
        rows[6]  = make_row(8'h05, 0, 8'd0,  1'b0, 4, 1'b1);
        rows[7]  = make_row(8'h40, 2, 8'd0,  1'b0, 2, 1'b0);
        rows[8]  = make_row(8'h07, 3, 8'd15, 1'b0, 1, 1'b0);
        rows[9]  = make_row(8'h41, 4, 8'd3,  1'b0, 0, 1'b0);
        rows[10] = make_row(8'h06, 1, 8'd3,  1'b0, 2, 1'b1);

        cycle_limit = 200;
        for (int i = 0; i < ROWS; i++) begin
            cycle_limit += 4 * (int'(rows[i].gap) + JUNK_WORDS + 3 +
                                int'(rows[i].hdr.length));
        end

        repeat (3) @(posedge rx_pixel_clk);
        arst_n <= 1'b1;
        @(negedge rx_pixel_clk);
        check_empty("uart_fifo_empty", uart_fifo_empty, 1'b1);
        check_empty("i2c_fifo_empty", i2c_fifo_empty, 1'b1);

        for (int i = 0; i < ROWS; i++) begin
            run_row(rows[i]);
        end
        @(posedge rx_pixel_clk);
        mipi_rx_valid <= 1'b0;
        read_on       <= 1'b1;

        // The last expected byte leaves on the edge before this negedge.
        do begin
            @(negedge rx_pixel_clk);
        end while ((uart_q.size() != 0) || (i2c_q.size() != 0));
        check_empty("uart_fifo_empty", uart_fifo_empty, 1'b1);
        check_empty("i2c_fifo_empty", i2c_fifo_empty, 1'b1);

        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
src/mipi_rx_pkg.sv
src/frame_fsm.sv
src/word_counter.sv
src/frame_buffer.sv
src/byte_unpacker.sv
src/byte_fifo.sv
src/mipi_rx_decoder.sv
tests/mipi_rx_decoder_asserts.sv
tests/tb_mipi_rx_decoder.sv

//--- Makefile
TOP := tb_mipi_rx_decoder

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
